// File: yuv420_defines.svh
`ifndef YUV420_DEFINES_SVH
`define YUV420_DEFINES_SVH

// beat type field
`define YUV_DTYPE_WIDTH 4

// beat codes, bit 3 marks a pixel
`define YUV_DT_FRAME_START  4'd0
`define YUV_DT_FRAME_END    4'd1
`define YUV_DT_HEADER_START 4'd2
`define YUV_DT_HEADER       4'd3
`define YUV_DT_HEADER_END   4'd4
`define YUV_DT_ROW_START    4'd5
`define YUV_DT_ROW_END      4'd6
`define YUV_DT_PIXEL        4'd8

// frame dimensions
`define YUV_MAX_COLS   1288
`define YUV_DIM_WIDTH  11
`define YUV_RESET_ROWS 720
`define YUV_RESET_COLS 1280

// metadata bits dropped to form the raw byte
`define YUV_RAW_SHIFT 0

// output word and accumulator widths
`define YUV_WORD_WIDTH 32
`define YUV_OBUF_WIDTH 56

`endif

// File: yuv420_pkg.sv
`include "yuv420_defines.svh"

package yuv420_pkg;

   // beat type carried with every beat
   typedef logic [`YUV_DTYPE_WIDTH-1:0] dtype_t;

   // one 8-bit sample of y, u or v
   typedef logic [7:0] pixel_t;

   // row or column count
   typedef logic [`YUV_DIM_WIDTH-1:0] dim_t;

   typedef logic [15:0] meta_t;

   // packed output word
   typedef logic [`YUV_WORD_WIDTH-1:0] word_t;

endpackage

// File: frame_geometry.sv
`timescale 1ns/100ps
`include "yuv420_defines.svh"

module frame_geometry (
   input  logic               clk,
   input  logic               resetb,
   input  logic               dvi,
   input  yuv420_pkg::dtype_t dtypei,
   output yuv420_pkg::dim_t   col_pos,
   output logic               uv_slot,
   output yuv420_pkg::dim_t   num_rows,
   output yuv420_pkg::dim_t   num_cols
);

   yuv420_pkg::dim_t row_pos;
   logic             pixel;
   logic             frame_start;
   logic             frame_end;
   logic             row_start;
   logic             row_end;

   assign pixel       = dvi && ((dtypei & `YUV_DT_PIXEL) != '0);
   assign frame_start = dvi && (dtypei == `YUV_DT_FRAME_START);
   assign frame_end   = dvi && (dtypei == `YUV_DT_FRAME_END);
   assign row_start   = dvi && (dtypei == `YUV_DT_ROW_START);
   assign row_end     = dvi && (dtypei == `YUV_DT_ROW_END);

   // u and v are emitted at the bottom right pixel of each 2x2 block
   assign uv_slot = row_pos[0] && col_pos[0];

   always_ff @(posedge clk or negedge resetb) begin
      if (!resetb) begin
         row_pos  <= '0;
         col_pos  <= '0;
         num_rows <= yuv420_pkg::dim_t'(`YUV_RESET_ROWS);
         num_cols <= yuv420_pkg::dim_t'(`YUV_RESET_COLS);
      end else begin
         if (frame_start) begin
            row_pos <= '0;
         end else if (row_end) begin
            row_pos <= row_pos + 1'b1;
         end else if (frame_end) begin
            // whole 2x2 blocks only
            num_rows <= {row_pos[`YUV_DIM_WIDTH-1:1], 1'b0};
            num_cols <= {col_pos[`YUV_DIM_WIDTH-1:1], 1'b0};
         end

         if (row_start) begin
            col_pos <= '0;
         end else if (pixel) begin
            col_pos <= col_pos + 1'b1;
         end
      end
   end

endmodule

// File: chroma_line_buffer.sv
`timescale 1ns/100ps
`include "yuv420_defines.svh"

module chroma_line_buffer #(
   parameter int depth = `YUV_MAX_COLS
) (
   input  logic               clk,
   input  logic               wr,
   input  yuv420_pkg::dim_t   col,
   input  yuv420_pkg::pixel_t u_in,
   input  yuv420_pkg::pixel_t v_in,
   output yuv420_pkg::pixel_t u_above,
   output yuv420_pkg::pixel_t v_above
);

   // one row of chroma, indexed by column
   yuv420_pkg::pixel_t mem_u [0:depth-1];
   yuv420_pkg::pixel_t mem_v [0:depth-1];

   // read before write, so the outputs hold the previous row's sample
   // and stay put between pixels
   always_ff @(posedge clk) begin
      if (wr) begin
         u_above    <= mem_u[col];
         v_above    <= mem_v[col];
         mem_u[col] <= u_in;
         mem_v[col] <= v_in;
      end
   end

endmodule

// File: chroma_kernel.sv
`timescale 1ns/100ps
`include "yuv420_defines.svh"

module chroma_kernel (
   input  logic               clk,
   input  logic               resetb,
   input  logic               dvi,
   input  yuv420_pkg::dtype_t dtypei,
   input  yuv420_pkg::meta_t  meta_datai,
   input  yuv420_pkg::pixel_t yi,
   input  yuv420_pkg::pixel_t ui,
   input  yuv420_pkg::pixel_t vi,
   input  yuv420_pkg::dim_t   col_pos,
   input  logic               uv_slot,
   output logic               k_dv,
   output yuv420_pkg::dtype_t k_dtype,
   output yuv420_pkg::meta_t  k_meta,
   output yuv420_pkg::pixel_t k_y,
   output yuv420_pkg::pixel_t k_u,
   output yuv420_pkg::pixel_t k_v,
   output yuv420_pkg::pixel_t k_u_ave,
   output yuv420_pkg::pixel_t k_v_ave,
   output logic               k_uv_slot
);

   logic               pixel;
   yuv420_pkg::pixel_t u_above;
   yuv420_pkg::pixel_t v_above;
   yuv420_pkg::pixel_t u_left;
   yuv420_pkg::pixel_t v_left;
   yuv420_pkg::pixel_t u_above_left;
   yuv420_pkg::pixel_t v_above_left;

   // floored mean of the four samples of a 2x2 block
   function automatic yuv420_pkg::pixel_t ave4(input yuv420_pkg::pixel_t a,
                                                input yuv420_pkg::pixel_t b,
                                                input yuv420_pkg::pixel_t c,
                                                input yuv420_pkg::pixel_t d);
      logic [9:0] sum;
      sum  = 10'(a) + 10'(b) + 10'(c) + 10'(d);
      ave4 = sum[9:2];
   endfunction

   assign pixel = dvi && ((dtypei & `YUV_DT_PIXEL) != '0);

   chroma_line_buffer u_line_buffer (
      .clk     (clk),
      .wr      (pixel),
      .col     (col_pos),
      .u_in    (ui),
      .v_in    (vi),
      .u_above (u_above),
      .v_above (v_above)
   );

   always_ff @(posedge clk or negedge resetb) begin
      if (!resetb) begin
         k_dv      <= 1'b0;
         k_dtype   <= '0;
         k_uv_slot <= 1'b0;
      end else begin
         k_dv      <= dvi;
         k_dtype   <= dtypei;
         k_uv_slot <= uv_slot;
      end
   end

   always_ff @(posedge clk) begin
      if (dvi) begin
         k_meta <= meta_datai;
         k_y    <= yi;
      end
      // left neighbours shift along only on pixel beats
      if (pixel) begin
         k_u          <= ui;
         k_v          <= vi;
         u_left       <= k_u;
         v_left       <= k_v;
         u_above_left <= u_above;
         v_above_left <= v_above;
      end
   end

   assign k_u_ave = ave4(k_u, u_left, u_above, u_above_left);
   assign k_v_ave = ave4(k_v, v_left, v_above, v_above_left);

endmodule

// File: word_packer.sv
`timescale 1ns/100ps
`include "yuv420_defines.svh"

module word_packer (
   input  logic               clk,
   input  logic               resetb,
   input  yuv420_pkg::meta_t  image_type,
   input  logic               enable_420,
   input  logic               k_dv,
   input  yuv420_pkg::dtype_t k_dtype,
   input  yuv420_pkg::meta_t  k_meta,
   input  yuv420_pkg::pixel_t k_y,
   input  yuv420_pkg::pixel_t k_u,
   input  yuv420_pkg::pixel_t k_v,
   input  yuv420_pkg::pixel_t k_u_ave,
   input  yuv420_pkg::pixel_t k_v_ave,
   input  logic               k_uv_slot,
   output logic               dvo,
   output yuv420_pkg::dtype_t dtypeo,
   output yuv420_pkg::word_t  datao
);

   localparam int OBUF_W = `YUV_OBUF_WIDTH;
   localparam int WORD_W = `YUV_WORD_WIDTH;

   logic [OBUF_W-1:0]  obuf;
   logic [OBUF_W-1:0]  next_obuf;
   logic [OBUF_W-1:0]  word_shift;
   logic [5:0]         opos;
   logic [5:0]         next_opos;
   logic [5:0]         next_opos_wrap;
   logic               hdr_phase;
   logic               flushed;
   yuv420_pkg::meta_t  raw_shift;
   yuv420_pkg::pixel_t raw_byte;
   yuv420_pkg::word_t  word;
   logic               pixel;
   logic               frame_start;
   logic               frame_end;
   logic               header_start;
   logic               header;
   logic               flush_req;

   assign pixel        = k_dv && ((k_dtype & `YUV_DT_PIXEL) != '0);
   assign frame_start  = k_dv && (k_dtype == `YUV_DT_FRAME_START);
   assign frame_end    = k_dv && (k_dtype == `YUV_DT_FRAME_END);
   assign header_start = k_dv && (k_dtype == `YUV_DT_HEADER_START);
   assign header       = k_dv && (k_dtype == `YUV_DT_HEADER);
   assign flush_req    = frame_end && (opos != '0);

   assign raw_shift = k_meta >> `YUV_RAW_SHIFT;
   assign raw_byte  = raw_shift[7:0];

   // newest bytes enter at the bottom, oldest sit above the fill count
   always_comb begin
      next_obuf = obuf;
      next_opos = opos;
      if (flush_req) begin
         // align pending bytes to the top of a word, zeros below
         next_obuf = obuf << (6'd32 - opos);
         next_opos = 6'd32;
      end else if (image_type == '0) begin
         next_obuf = {obuf[OBUF_W-9:0], raw_byte};
         next_opos = opos + 6'd8;
      end else if (!enable_420) begin
         next_obuf = {obuf[OBUF_W-25:0], k_y, k_u, k_v};
         next_opos = opos + 6'd24;
      end else if (k_uv_slot) begin
         next_obuf = {obuf[OBUF_W-25:0], k_y, k_u_ave, k_v_ave};
         next_opos = opos + 6'd24;
      end else begin
         next_obuf = {obuf[OBUF_W-9:0], k_y};
         next_opos = opos + 6'd8;
      end
   end

   assign next_opos_wrap = next_opos - 6'd32;
   assign word_shift     = next_obuf >> next_opos_wrap;
   assign word           = word_shift[WORD_W-1:0];

   always_ff @(posedge clk) begin
      if (pixel || flush_req) begin
         obuf <= next_obuf;
      end
   end

   always_ff @(posedge clk or negedge resetb) begin
      if (!resetb) begin
         dvo       <= 1'b0;
         dtypeo    <= '0;
         datao     <= '0;
         opos      <= '0;
         hdr_phase <= 1'b0;
         flushed   <= 1'b0;
      end else begin
         flushed <= flush_req;

         // the frame end beat follows one cycle behind its flush word
         if (flush_req) begin
            dtypeo <= `YUV_DT_PIXEL;
         end else if (flushed) begin
            dtypeo <= `YUV_DT_FRAME_END;
         end else begin
            dtypeo <= k_dtype;
         end

         if (pixel || flush_req) begin
            if (next_opos >= 6'd32) begin
               dvo   <= 1'b1;
               // first stream byte goes out in the low byte
               datao <= {word[7:0], word[15:8], word[23:16], word[31:24]};
               opos  <= next_opos_wrap;
            end else begin
               dvo  <= 1'b0;
               opos <= next_opos;
            end
         end else if (frame_start || header_start) begin
            opos      <= '0;
            hdr_phase <= 1'b0;
            dvo       <= 1'b1;
            datao     <= '0;
         end else if (header) begin
            hdr_phase <= ~hdr_phase;
            if (hdr_phase) begin
               datao[31:16] <= k_meta;
               dvo          <= 1'b1;
            end else begin
               datao[15:0] <= k_meta;
               dvo         <= 1'b0;
            end
         end else if (flushed) begin
            dvo   <= 1'b1;
            datao <= '0;
         end else begin
            dvo   <= k_dv;
            datao <= '0;
         end
      end
   end

endmodule

// File: yuv420_packer_top.sv
`timescale 1ns/100ps

module yuv420_packer_top (
   input  logic               clk,
   input  logic               resetb,
   input  yuv420_pkg::meta_t  image_type,
   input  logic               enable_420,
   input  logic               dvi,
   input  yuv420_pkg::dtype_t dtypei,
   input  yuv420_pkg::meta_t  meta_datai,
   input  yuv420_pkg::pixel_t yi,
   input  yuv420_pkg::pixel_t ui,
   input  yuv420_pkg::pixel_t vi,
   output yuv420_pkg::dim_t   num_rows,
   output yuv420_pkg::dim_t   num_cols,
   output logic               dvo,
   output yuv420_pkg::dtype_t dtypeo,
   output yuv420_pkg::word_t  datao
);

   yuv420_pkg::dim_t   col_pos;
   logic               uv_slot;
   logic               k_dv;
   yuv420_pkg::dtype_t k_dtype;
   yuv420_pkg::meta_t  k_meta;
   yuv420_pkg::pixel_t k_y;
   yuv420_pkg::pixel_t k_u;
   yuv420_pkg::pixel_t k_v;
   yuv420_pkg::pixel_t k_u_ave;
   yuv420_pkg::pixel_t k_v_ave;
   logic               k_uv_slot;

   // position tracking on the raw input beats
   frame_geometry u_geometry (
      .clk      (clk),
      .resetb   (resetb),
      .dvi      (dvi),
      .dtypei   (dtypei),
      .col_pos  (col_pos),
      .uv_slot  (uv_slot),
      .num_rows (num_rows),
      .num_cols (num_cols)
   );

   chroma_kernel u_kernel (
      .clk        (clk),
      .resetb     (resetb),
      .dvi        (dvi),
      .dtypei     (dtypei),
      .meta_datai (meta_datai),
      .yi         (yi),
      .ui         (ui),
      .vi         (vi),
      .col_pos    (col_pos),
      .uv_slot    (uv_slot),
      .k_dv       (k_dv),
      .k_dtype    (k_dtype),
      .k_meta     (k_meta),
      .k_y        (k_y),
      .k_u        (k_u),
      .k_v        (k_v),
      .k_u_ave    (k_u_ave),
      .k_v_ave    (k_v_ave),
      .k_uv_slot  (k_uv_slot)
   );

   word_packer u_packer (
      .clk        (clk),
      .resetb     (resetb),
      .image_type (image_type),
      .enable_420 (enable_420),
      .k_dv       (k_dv),
      .k_dtype    (k_dtype),
      .k_meta     (k_meta),
      .k_y        (k_y),
      .k_u        (k_u),
      .k_v        (k_v),
      .k_u_ave    (k_u_ave),
      .k_v_ave    (k_v_ave),
      .k_uv_slot  (k_uv_slot),
      .dvo        (dvo),
      .dtypeo     (dtypeo),
      .datao      (datao)
   );

endmodule

// File: tb_yuv420_packer.sv
`timescale 1ns/100ps
`include "yuv420_defines.svh"

module tb_yuv420_packer;

   logic               clk;
   logic               resetb;
   yuv420_pkg::meta_t  image_type;
   logic               enable_420;
   logic               dvi;
   yuv420_pkg::dtype_t dtypei;
   yuv420_pkg::meta_t  meta_datai;
   yuv420_pkg::pixel_t yi;
   yuv420_pkg::pixel_t ui;
   yuv420_pkg::pixel_t vi;
   yuv420_pkg::dim_t   num_rows;
   yuv420_pkg::dim_t   num_cols;
   logic               dvo;
   yuv420_pkg::dtype_t dtypeo;
   yuv420_pkg::word_t  datao;

   // expected output beats in arrival order
   yuv420_pkg::dtype_t exp_type [$];
   yuv420_pkg::word_t  exp_data [$];
   // stream bytes still short of a whole word
   yuv420_pkg::pixel_t pending [$];
   // chroma of the frame being sent, kept for the 2x2 means
   yuv420_pkg::pixel_t u_frame [0:7][0:7];
   yuv420_pkg::pixel_t v_frame [0:7][0:7];

   yuv420_packer_top u_dut (
      .clk        (clk),
      .resetb     (resetb),
      .image_type (image_type),
      .enable_420 (enable_420),
      .dvi        (dvi),
      .dtypei     (dtypei),
      .meta_datai (meta_datai),
      .yi         (yi),
      .ui         (ui),
      .vi         (vi),
      .num_rows   (num_rows),
      .num_cols   (num_cols),
      .dvo        (dvo),
      .dtypeo     (dtypeo),
      .datao      (datao)
   );

   initial begin
      clk = 1'b0;
      forever #20 clk = ~clk;
   end

   task automatic stop_run(input string why);
      $display("%s", why);
      $display("Simulation FAILED");
      $fatal(1);
   endtask

   function automatic yuv420_pkg::pixel_t block_mean(input int a, input int b,
                                                      input int c, input int d);
      int sum;
      sum = a + b + c + d;
      return yuv420_pkg::pixel_t'(sum / 4);
   endfunction

   task automatic expect_beat(input yuv420_pkg::dtype_t t, input yuv420_pkg::word_t d);
      exp_type.push_back(t);
      exp_data.push_back(d);
   endtask

   // first stream byte lands in the lowest byte of the word
   task automatic expect_byte(input yuv420_pkg::pixel_t b);
      pending.push_back(b);
      if (pending.size() == 4) begin
         expect_beat(`YUV_DT_PIXEL, {pending[3], pending[2], pending[1], pending[0]});
         pending.delete();
      end
   endtask

   // zero bytes fill the partial word up from the top
   task automatic expect_flush();
      while (pending.size() != 0) begin
         expect_byte(8'h00);
      end
   endtask

   task automatic drive_beat(input yuv420_pkg::dtype_t t, input yuv420_pkg::meta_t m,
                             input yuv420_pkg::pixel_t y, input yuv420_pkg::pixel_t u,
                             input yuv420_pkg::pixel_t v);
      @(posedge clk);
      #2;
      dvi        = 1'b1;
      dtypei     = t;
      meta_datai = m;
      yi         = y;
      ui         = u;
      vi         = v;
   endtask

   task automatic drive_idle();
      @(posedge clk);
      #2;
      dvi    = 1'b0;
      dtypei = '0;
   endtask

   task automatic set_mode(input yuv420_pkg::meta_t itype, input logic en_420);
      @(posedge clk);
      #2;
      image_type = itype;
      enable_420 = en_420;
   endtask

   // framing beats pass through with a zero word
   task automatic send_marker(input yuv420_pkg::dtype_t t);
      expect_beat(t, '0);
      drive_beat(t, 16'h0000, 8'h00, 8'h00, 8'h00);
   endtask

   task automatic send_pixel(input int r, input int c);
      yuv420_pkg::pixel_t y;
      yuv420_pkg::pixel_t u;
      yuv420_pkg::pixel_t v;
      yuv420_pkg::meta_t  m;
      yuv420_pkg::meta_t  raw;
      y = 8'($urandom());
      u = 8'($urandom());
      v = 8'($urandom());
      m = 16'($urandom());
      u_frame[r][c] = u;
      v_frame[r][c] = v;
      raw = m >> `YUV_RAW_SHIFT;
      if (image_type == '0) begin
         expect_byte(raw[7:0]);
      end else if (!enable_420) begin
         expect_byte(y);
         expect_byte(u);
         expect_byte(v);
      end else if ((r % 2 == 1) && (c % 2 == 1)) begin
         // bottom right of a 2x2 block carries the block's chroma
         expect_byte(y);
         expect_byte(block_mean(u, u_frame[r][c-1], u_frame[r-1][c], u_frame[r-1][c-1]));
         expect_byte(block_mean(v, v_frame[r][c-1], v_frame[r-1][c], v_frame[r-1][c-1]));
      end else begin
         expect_byte(y);
      end
      drive_beat(`YUV_DT_PIXEL, m, y, u, v);
   endtask

   task automatic wait_drained();
      int cycles;
      cycles = 0;
      while ((exp_type.size() != 0) && (cycles < 200)) begin
         @(posedge clk);
         cycles++;
      end
      if (exp_type.size() != 0) begin
         stop_run("timed out waiting for the expected output beats");
      end
   endtask

   task automatic check_dims(input yuv420_pkg::dim_t rows, input yuv420_pkg::dim_t cols);
      @(negedge clk);
      assert (num_rows == rows)
         else stop_run($sformatf("FAIL num_rows: got %h, expected %h", num_rows, rows));
      assert (num_cols == cols)
         else stop_run($sformatf("FAIL num_cols: got %h, expected %h", num_cols, cols));
   endtask

   task automatic send_frame(input int rows, input int cols, input int hdr_beats);
      int                k;
      int                r;
      int                c;
      yuv420_pkg::meta_t hdr_low;
      yuv420_pkg::meta_t m;
      hdr_low = '0;
      send_marker(`YUV_DT_FRAME_START);
      if (hdr_beats > 0) begin
         send_marker(`YUV_DT_HEADER_START);
         for (k = 0; k < hdr_beats; k++) begin
            m = 16'($urandom());
            // first beat of a pair fills the low half
            if (k % 2 == 0) begin
               hdr_low = m;
            end else begin
               expect_beat(`YUV_DT_HEADER, {m, hdr_low});
            end
            drive_beat(`YUV_DT_HEADER, m, 8'h00, 8'h00, 8'h00);
         end
         send_marker(`YUV_DT_HEADER_END);
      end
      for (r = 0; r < rows; r++) begin
         send_marker(`YUV_DT_ROW_START);
         for (c = 0; c < cols; c++) begin
            send_pixel(r, c);
         end
         send_marker(`YUV_DT_ROW_END);
      end
      expect_flush();
      send_marker(`YUV_DT_FRAME_END);
      drive_idle();
      wait_drained();
      check_dims(yuv420_pkg::dim_t'(rows & ~1), yuv420_pkg::dim_t'(cols & ~1));
   endtask

   // each output beat is matched against the head of the expected queue
   always @(negedge clk) begin : check_outputs
      yuv420_pkg::dtype_t t;
      yuv420_pkg::word_t  d;
      if (resetb && dvo) begin
         if (exp_type.size() == 0) begin
            stop_run("an output beat appeared when none was expected");
         end else begin
            t = exp_type.pop_front();
            d = exp_data.pop_front();
            assert (dtypeo == t)
               else stop_run($sformatf("FAIL dtypeo: got %h, expected %h", dtypeo, t));
            assert (datao == d)
               else stop_run($sformatf("FAIL datao: got %h, expected %h", datao, d));
         end
      end
   end

   initial begin
      resetb     = 1'b0;
      image_type = 16'h0001;
      enable_420 = 1'b0;
      dvi        = 1'b0;
      dtypei     = '0;
      meta_datai = '0;
      yi         = '0;
      ui         = '0;
      vi         = '0;
      void'($urandom(32'h910d5111));
      repeat (16) @(posedge clk);
      #2;
      resetb = 1'b1;
      repeat (2) @(posedge clk);
      @(negedge clk);
      assert (dvo == 1'b0)
         else stop_run($sformatf("FAIL dvo: got %h, expected %h", dvo, 1'b0));
      check_dims(yuv420_pkg::dim_t'(`YUV_RESET_ROWS), yuv420_pkg::dim_t'(`YUV_RESET_COLS));

      // 4:4:4 pass through
      send_frame(4, 4, 0);
      // 4:2:0 on a square frame, then an odd sized one with a flush
      set_mode(16'h0001, 1'b1);
      send_frame(4, 4, 0);
      send_frame(3, 5, 0);
      // raw bytes from the metadata
      set_mode(16'h0000, 1'b1);
      send_frame(3, 3, 0);
      // header pairs ahead of a small frame
      set_mode(16'h0001, 1'b1);
      send_frame(2, 2, 4);

      // quiet tail so stray output beats are still caught
      repeat (8) @(posedge clk);
      $display("Simulation PASSED");
      $finish;
   end

endmodule

// File: files.f
+incdir+.
yuv420_pkg.sv
frame_geometry.sv
chroma_line_buffer.sv
chroma_kernel.sv
word_packer.sv
yuv420_packer_top.sv
tb_yuv420_packer.sv

// File: Makefile
.PHONY: help test clean

help:
	@echo "targets:"
	@echo "  test   build the testbench with Verilator and run it"
	@echo "  clean  remove the Verilator build directory"
	@echo "  help   show this list"

test:
	verilator --binary --timing --assert -Wno-fatal --top-module tb_yuv420_packer -f files.f
	./obj_dir/Vtb_yuv420_packer

clean:
	rm -rf obj_dir
